// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_sd_cmd_phy
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: src/sd_cmd_phy.sv
// ======================================================================
// SD command-line PHY top level. Joins the command receiver and the
// response transmitter; the transmitter's output enable also masks
// the receiver so the PHY never decodes its own responses.
// ======================================================================
`timescale 1ns/1ps

module sd_cmd_phy (
   input  logic                               sd_clk,
   input  logic                               reset_n,

   // CMD pin
   input  logic                               sd_cmd_in,
   output logic                               sd_cmd_out,
   output logic                               sd_cmd_oe,

   // received commands
   output logic                               cmd_valid,
   output logic [sd_cmd_pkg::CMD_BITS-1:0]    cmd_data,
   output logic                               cmd_crc_ok,

   // responses from the link
   input  logic                               resp_start,
   input  logic [sd_cmd_pkg::RESP_TYPE_W-1:0] resp_type,
   input  logic [sd_cmd_pkg::RESP_DATA_W-1:0] resp_data,
   output logic                               resp_done
);

   sd_cmd_rx cmd_rx_i (
      .sd_clk     (sd_clk),
      .reset_n    (reset_n),
      .sd_cmd_in  (sd_cmd_in),
      .sd_cmd_oe  (sd_cmd_oe),
      .cmd_valid  (cmd_valid),
      .cmd_data   (cmd_data),
      .cmd_crc_ok (cmd_crc_ok)
   );

   // drives the pin and feeds oe back to the receiver
   sd_resp_tx resp_tx_i (
      .sd_clk     (sd_clk),
      .reset_n    (reset_n),
      .resp_start (resp_start),
      .resp_type  (resp_type),
      .resp_data  (resp_data),
      .sd_cmd_out (sd_cmd_out),
      .sd_cmd_oe  (sd_cmd_oe),
      .resp_done  (resp_done)
   );

endmodule

// File: src/sd_cmd_pkg.sv
// ======================================================================
// Shared constants for the SD command-line PHY.
// Frame lengths, CRC coverage, power-up timing and response-type codes,
// referenced from the RTL as sd_cmd_pkg::name.
// ======================================================================

package sd_cmd_pkg;

   // command and short response frames
   localparam int CMD_BITS     = 48;
   localparam int CMD_CRC_SPAN = 40;

   // R2 long response
   localparam int LONG_RESP_BITS = 136;
   localparam int LONG_CRC_SKIP  = 8;

   localparam int CRC7_W = 7;

   // high CMD clocks from the host before the first command
   localparam int INIT_WAIT_CLOCKS = 60;

   // response-type codes as driven by the link
   localparam int RESP_TYPE_W = 4;

   localparam logic [RESP_TYPE_W-1:0] RESP_R1  = 4'd1;
   localparam logic [RESP_TYPE_W-1:0] RESP_R1B = 4'd2;
   localparam logic [RESP_TYPE_W-1:0] RESP_R2  = 4'd3;
   localparam logic [RESP_TYPE_W-1:0] RESP_R3  = 4'd4;
   localparam logic [RESP_TYPE_W-1:0] RESP_R6  = 4'd5;
   localparam logic [RESP_TYPE_W-1:0] RESP_R7  = 4'd6;

   // sized for the longest (R2) response
   localparam int RESP_DATA_W = 136;

endpackage

// File: src/sd_cmd_rx.sv
// ======================================================================
// SD command receiver. Waits out the host's power-up clocks, then finds
// start bits on CMD, shifts in 48-bit commands and checks their CRC7.
// cmd_valid pulses for one cycle with cmd_data and cmd_crc_ok.
// ======================================================================
`timescale 1ns/1ps

module sd_cmd_rx (
   input  logic                            sd_clk,
   input  logic                            reset_n,
   input  logic                            sd_cmd_in,
   input  logic                            sd_cmd_oe,
   output logic                            cmd_valid,
   output logic [sd_cmd_pkg::CMD_BITS-1:0] cmd_data,
   output logic                            cmd_crc_ok
);

   localparam int CNT_W = $clog2(sd_cmd_pkg::INIT_WAIT_CLOCKS + sd_cmd_pkg::CMD_BITS);

   typedef enum logic [2:0] {
      st_reset,
      st_wait,
      st_idle,
      st_read,
      st_check
   } state_t;

   state_t                            state;
   logic [CNT_W-1:0]                  cnt;
   logic                              cmd_last;
   logic [sd_cmd_pkg::CMD_BITS-2:0]   shreg;
   logic [sd_cmd_pkg::CRC7_W-1:0]     crc;
   logic                              start_det;
   logic                              crc_adv;

   // high-to-low on CMD while we are not driving it
   assign start_det = (state == st_idle) && !sd_cmd_in && cmd_last && !sd_cmd_oe;

   // start bit is zero and leaves a zero CRC unchanged, so only bits 1..39 are folded
   assign crc_adv = (state == st_read) &&
                    (cnt < CNT_W'(sd_cmd_pkg::CMD_CRC_SPAN - 1));

   sd_crc7 crc_i (
      .sd_clk    (sd_clk),
      .reset_n   (reset_n),
      .clear     (state == st_idle),
      .advance   (crc_adv),
      .bit_in    (sd_cmd_in),
      .shift_out (1'b0),
      .fill_ones (1'b0),
      .crc       (crc)
   );

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state     <= st_reset;
         cnt       <= '0;
         cmd_last  <= 1'b0;
         cmd_valid <= 1'b0;
      end else begin
         cmd_last  <= sd_cmd_in;
         cmd_valid <= 1'b0;
         case (state)
            st_reset: begin
               cnt <= '0;
               if (sd_cmd_in) state <= st_wait;
            end
            st_wait: begin
               // host clocks CMD high before its first command
               cnt <= cnt + 1'b1;
               if (cnt == CNT_W'(sd_cmd_pkg::INIT_WAIT_CLOCKS - 1)) state <= st_idle;
            end
            st_idle: begin
               cnt <= '0;
               if (start_det) state <= st_read;
            end
            st_read: begin
               cnt <= cnt + 1'b1;
               // bit 46 is the last one shifted here
               if (cnt == CNT_W'(sd_cmd_pkg::CMD_BITS - 3)) state <= st_check;
            end
            st_check: begin
               // transmission bit must be 1 for a host command
               cmd_valid <= shreg[sd_cmd_pkg::CMD_BITS-3];
               state     <= st_idle;
            end
            default: state <= st_reset;
         endcase
      end
   end

   // frame bits, start bit sits at the top as a zero
   always_ff @(posedge sd_clk) begin
      if (start_det) begin
         shreg <= '0;
      end else if (state == st_read) begin
         shreg <= {shreg[sd_cmd_pkg::CMD_BITS-3:0], sd_cmd_in};
      end
      if (state == st_check) begin
         cmd_data   <= {shreg, sd_cmd_in};
         cmd_crc_ok <= (shreg[sd_cmd_pkg::CRC7_W-1:0] == crc);
      end
   end

endmodule

// File: src/sd_crc7.sv
// ======================================================================
// CRC7 register for the SD command line, polynomial x^7 + x^3 + 1.
// advance folds one bit in MSB first; shift_out walks the result out of
// the top bit and backfills ones, so the end bit follows the CRC field.
// ======================================================================
`timescale 1ns/1ps

module sd_crc7 (
   input  logic                          sd_clk,
   input  logic                          reset_n,
   input  logic                          clear,
   input  logic                          advance,
   input  logic                          bit_in,
   input  logic                          shift_out,
   input  logic                          fill_ones,
   output logic [sd_cmd_pkg::CRC7_W-1:0] crc
);

   logic feedback;

   // top bit out xor incoming bit
   assign feedback = bit_in ^ crc[sd_cmd_pkg::CRC7_W-1];

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         crc <= '0;
      end else if (clear) begin
         crc <= '0;
      end else if (fill_ones) begin
         crc <= '1;
      end else if (shift_out) begin
         crc <= {crc[sd_cmd_pkg::CRC7_W-2:0], 1'b1};
      end else if (advance) begin
         // taps at x^3 and x^0
         crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
      end
   end

endmodule

// File: src/sd_resp_tx.sv
// ======================================================================
// SD response transmitter. Latches a response on resp_start, serializes
// it onto CMD with generated CRC7 and end bit, then pulses resp_done.
// Short types send 48 bits, R2 sends 136; R3 carries an all-ones CRC.
// ======================================================================
`timescale 1ns/1ps

module sd_resp_tx (
   input  logic                               sd_clk,
   input  logic                               reset_n,
   input  logic                               resp_start,
   input  logic [sd_cmd_pkg::RESP_TYPE_W-1:0] resp_type,
   input  logic [sd_cmd_pkg::RESP_DATA_W-1:0] resp_data,
   output logic                               sd_cmd_out,
   output logic                               sd_cmd_oe,
   output logic                               resp_done
);

   localparam int CNT_W = $clog2(sd_cmd_pkg::LONG_RESP_BITS);

   typedef enum logic [1:0] {
      st_idle,
      st_preamble,
      st_write,
      st_end
   } state_t;

   state_t                                state;
   logic [CNT_W-1:0]                      cnt;
   logic [sd_cmd_pkg::RESP_TYPE_W-1:0]    type_q;
   logic [sd_cmd_pkg::RESP_DATA_W-1:0]    shreg;
   logic [sd_cmd_pkg::CRC7_W-1:0]         crc;
   logic [CNT_W-1:0]                      crc_start;
   logic [CNT_W-1:0]                      last_cnt;
   logic                                  type_ok;
   logic                                  accept;
   logic                                  is_long;
   logic                                  is_r3;
   logic                                  writing;
   logic                                  in_payload;
   logic                                  in_crc_skip;
   logic                                  tx_bit;

   // unknown codes are dropped rather than sent with an undefined length
   assign type_ok = resp_type inside {sd_cmd_pkg::RESP_R1, sd_cmd_pkg::RESP_R1B,
                                      sd_cmd_pkg::RESP_R2, sd_cmd_pkg::RESP_R3,
                                      sd_cmd_pkg::RESP_R6, sd_cmd_pkg::RESP_R7};
   assign accept  = (state == st_idle) && resp_start && type_ok;

   assign is_long = (type_q == sd_cmd_pkg::RESP_R2);
   assign is_r3   = (type_q == sd_cmd_pkg::RESP_R3);
   assign writing = (state == st_write);

   // first CRC bit position and last frame bit, per frame length
   assign crc_start = is_long ?
      CNT_W'(sd_cmd_pkg::LONG_RESP_BITS - sd_cmd_pkg::CRC7_W - 1) :
      CNT_W'(sd_cmd_pkg::CMD_CRC_SPAN);
   assign last_cnt  = is_long ?
      CNT_W'(sd_cmd_pkg::LONG_RESP_BITS - 1) :
      CNT_W'(sd_cmd_pkg::CMD_BITS - 1);

   assign in_payload  = writing && (cnt < crc_start);
   // R2 CRC leaves out the start, transmission and reserved bits
   assign in_crc_skip = writing && is_long && (cnt < CNT_W'(sd_cmd_pkg::LONG_CRC_SKIP));

   assign tx_bit = in_payload ? shreg[sd_cmd_pkg::RESP_DATA_W-1] :
                                crc[sd_cmd_pkg::CRC7_W-1];

   sd_crc7 crc_i (
      .sd_clk    (sd_clk),
      .reset_n   (reset_n),
      .clear     ((state == st_idle) || in_crc_skip),
      .advance   (in_payload),
      .bit_in    (shreg[sd_cmd_pkg::RESP_DATA_W-1]),
      .shift_out (writing && !in_payload),
      .fill_ones (in_payload && is_r3),
      .crc       (crc)
   );

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state      <= st_idle;
         cnt        <= '0;
         sd_cmd_oe  <= 1'b0;
         sd_cmd_out <= 1'b1;
         resp_done  <= 1'b0;
      end else begin
         resp_done <= 1'b0;
         case (state)
            st_idle: begin
               if (accept) state <= st_preamble;
            end
            st_preamble: begin
               // one spare cycle keeps the fixed command-to-response gap
               cnt   <= '0;
               state <= st_write;
            end
            st_write: begin
               sd_cmd_oe  <= 1'b1;
               sd_cmd_out <= tx_bit;
               cnt        <= cnt + 1'b1;
               // end bit comes from the ones backfilled behind the CRC
               if (cnt == last_cnt) state <= st_end;
            end
            st_end: begin
               sd_cmd_oe  <= 1'b0;
               sd_cmd_out <= 1'b1;
               resp_done  <= 1'b1;
               state      <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // response payload, msb first
   always_ff @(posedge sd_clk) begin
      if (accept) begin
         type_q <= resp_type;
         shreg  <= resp_data;
      end else if (writing) begin
         shreg <= {shreg[sd_cmd_pkg::RESP_DATA_W-2:0], 1'b1};
      end
   end

endmodule

// File: verif/sd_cmd_model.svh
// ======================================================================
// Testbench model of the SD command line: a CRC7 reference, frame
// builders, a serializer for host commands and a capture of responses.
// Included inside the testbench module and drives its signals directly.
// ======================================================================
`ifndef SD_CMD_MODEL_SVH
`define SD_CMD_MODEL_SVH

// crc7 with x^7 + x^3 + 1 and a zero seed over the top nbits of a left-aligned vector
function automatic logic [6:0] crc7_ref(input logic [135:0] bits, input int nbits);
   logic [6:0] c;
   logic       fb;
   c = 7'h00;
   for (int i = 0; i < nbits; i++) begin
      fb   = bits[135] ^ c[6];
      c    = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
      bits = bits << 1;
   end
   return c;
endfunction

// start bit, transmission bit, 38 body bits, crc, end bit
function automatic logic [47:0] build_command(input logic trans, input logic [37:0] body);
   logic [39:0] head;
   head = {1'b0, trans, body};
   return {head, crc7_ref({head, 96'h0}, 40), 1'b1};
endfunction

function automatic logic [47:0] short_frame(input logic [135:0] data, input logic is_r3);
   logic [6:0] crc;
   crc = is_r3 ? 7'h7F : crc7_ref(data, 40);
   return {data[135:96], crc, 1'b1};
endfunction

// R2 crc starts after the first 8 frame bits
function automatic logic [135:0] long_frame(input logic [135:0] data);
   return {data[135:8], crc7_ref({data[127:0], 8'h00}, 120), 1'b1};
endfunction

// called just after a rising edge so that bit k is sampled at edge Ek
task automatic send_command(input logic [47:0] frame);
   logic [47:0] bits;
   bits = frame;
   repeat (48) begin
      sd_cmd_in = bits[47];
      bits      = bits << 1;
      @(posedge sd_clk);
      #DRIVE_DELAY;
   end
   sd_cmd_in = 1'b1;
endtask

// lead counts falling edges until oe is seen high
task automatic capture_response(output logic [135:0] bits, output int lead,
                                output int n_high, output logic done_once);
   logic early;
   lead      = 0;
   n_high    = 0;
   bits      = '0;
   done_once = 1'b0;
   early     = 1'b0;
   do begin
      @(negedge sd_clk);
      lead++;
      if (resp_done) early = 1'b1;
   end while (!sd_cmd_oe && lead < 20);
   while (sd_cmd_oe && n_high < 200) begin
      if (resp_done) early = 1'b1;
      bits = {bits[134:0], sd_cmd_out};
      n_high++;
      @(negedge sd_clk);
   end
   // done must be high right after oe falls, and only for that cycle
   done_once = resp_done && !early;
   @(negedge sd_clk);
   if (resp_done) done_once = 1'b0;
endtask

`endif

// File: verif/tb_sd_cmd_phy.sv
// ======================================================================
// Testbench for the SD command-line PHY. Sends random host commands on
// CMD and random responses through the link, and checks both against
// the model in the included header. Prints one line per test.
// ======================================================================
`timescale 1ns/1ps

module tb_sd_cmd_phy;

   localparam int CLK_HALF     = 10;
   localparam int DRIVE_DELAY  = 2;
   localparam int RESET_CYCLES = 16;
   localparam int N_GOOD       = 20;
   localparam int N_BADCRC     = 8;
   localparam int N_TXZERO     = 4;
   localparam int N_SHORT      = 12;
   localparam int N_LONG       = 6;
   localparam int N_TESTS      = 2 + N_GOOD + N_BADCRC + N_TXZERO + N_SHORT + N_LONG;
   localparam int WATCHDOG_CYCLES =
      N_TESTS * 400 + sd_cmd_pkg::INIT_WAIT_CLOCKS + RESET_CYCLES;

   logic         sd_clk;
   logic         reset_n;
   logic         sd_cmd_in;
   logic         sd_cmd_out;
   logic         sd_cmd_oe;
   logic         cmd_valid;
   logic [47:0]  cmd_data;
   logic         cmd_crc_ok;
   logic         resp_start;
   logic [3:0]   resp_type;
   logic [135:0] resp_data;
   logic         resp_done;

   logic [47:0]  rx_data_q[$];
   logic         rx_ok_q[$];
   logic         in_power_up;
   int           noisy_cycles;
   string        test_name;
   logic         test_failed;
   int           pass_count;
   int           fail_count;
   int unsigned  seed;

   sd_cmd_phy dut_i (
      .sd_clk     (sd_clk),
      .reset_n    (reset_n),
      .sd_cmd_in  (sd_cmd_in),
      .sd_cmd_out (sd_cmd_out),
      .sd_cmd_oe  (sd_cmd_oe),
      .cmd_valid  (cmd_valid),
      .cmd_data   (cmd_data),
      .cmd_crc_ok (cmd_crc_ok),
      .resp_start (resp_start),
      .resp_type  (resp_type),
      .resp_data  (resp_data),
      .resp_done  (resp_done)
   );

   `include "sd_cmd_model.svh"

   always #CLK_HALF sd_clk = ~sd_clk;

   // received commands, sampled mid-cycle
   always @(negedge sd_clk) begin
      if (cmd_valid) begin
         rx_data_q.push_back(cmd_data);
         rx_ok_q.push_back(cmd_crc_ok);
      end
      if (in_power_up && (cmd_valid || sd_cmd_oe || resp_done)) noisy_cycles++;
   end

   function automatic logic [135:0] random_bits();
      logic [159:0] r;
      r = {$urandom, $urandom, $urandom, $urandom, $urandom};
      return r[135:0];
   endfunction

   task automatic next_cycle();
      @(posedge sd_clk);
      #DRIVE_DELAY;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_failed = 1'b0;
   endtask

   task automatic end_test();
      if (test_failed) begin
         fail_count++;
         $display("FAIL %s", test_name);
      end else begin
         pass_count++;
         $display("pass %s", test_name);
      end
   endtask

   task automatic report_mismatch(input string what, input logic [135:0] expected,
                                  input logic [135:0] actual);
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      test_failed = 1'b1;
   endtask

   task automatic report_problem(input string msg);
      $display("[ERROR] %s: %s", test_name, msg);
      test_failed = 1'b1;
   endtask

   task automatic pulse_response(input logic [3:0] rtype, input logic [135:0] data);
      resp_type  = rtype;
      resp_data  = data;
      resp_start = 1'b1;
      next_cycle();
      resp_start = 1'b0;
   endtask

   task automatic check_command(input logic [47:0] exp_frame, input logic exp_ok);
      int waited;
      waited = 0;
      while (rx_data_q.size() == 0 && waited < 10) begin
         next_cycle();
         waited++;
      end
      // a second pulse would land in these cycles
      wait_cycles(4);
      if (rx_data_q.size() != 1) begin
         report_problem($sformatf("expected one cmd_valid, saw %0d", rx_data_q.size()));
      end else begin
         if (rx_data_q[0] != exp_frame)
            report_mismatch("cmd_data", 136'(exp_frame), 136'(rx_data_q[0]));
         if (rx_ok_q[0] != exp_ok)
            report_mismatch("cmd_crc_ok", 136'(exp_ok), 136'(rx_ok_q[0]));
      end
      rx_data_q.delete();
      rx_ok_q.delete();
   endtask

   task automatic check_response(input logic [3:0] rtype, input logic [135:0] data,
                                 input logic retrigger);
      logic [135:0] bits;
      logic [135:0] expected;
      int           lead;
      int           n_high;
      int           exp_len;
      logic         done_once;
      logic         extra;
      if (rtype == sd_cmd_pkg::RESP_R2) begin
         exp_len  = sd_cmd_pkg::LONG_RESP_BITS;
         expected = long_frame(data);
      end else begin
         exp_len  = sd_cmd_pkg::CMD_BITS;
         expected = 136'(short_frame(data, rtype == sd_cmd_pkg::RESP_R3));
      end
      pulse_response(rtype, data);
      fork
         capture_response(bits, lead, n_high, done_once);
         if (retrigger) begin
            wait_cycles(60);
            pulse_response(sd_cmd_pkg::RESP_R1, random_bits());
         end
      join
      extra = 1'b0;
      repeat (10) begin
         @(negedge sd_clk);
         if (sd_cmd_oe) extra = 1'b1;
      end
      next_cycle();
      // oe rises after the second edge following the one that took resp_start
      if (lead != 3) report_mismatch("oe delay", 136'(3), 136'(lead));
      if (n_high != exp_len) report_mismatch("oe cycles", 136'(exp_len), 136'(n_high));
      if (bits != expected) report_mismatch("frame", expected, bits);
      if (!done_once) report_problem("resp_done did not pulse once right after oe fell");
      if (extra) report_problem("a resp_start while busy started a second response");
   endtask

   initial begin
      logic [47:0]  frame;
      logic [135:0] r;
      logic [6:0]   flip;
      logic [3:0]   rtype;
      seed         = $urandom(51);
      sd_clk       = 1'b0;
      reset_n      = 1'b0;
      sd_cmd_in    = 1'b1;
      resp_start   = 1'b0;
      resp_type    = '0;
      resp_data    = '0;
      in_power_up  = 1'b1;
      noisy_cycles = 0;
      pass_count   = 0;
      fail_count   = 0;

      // CMD0 and CMD17 carry well-known CRC fields
      begin_test("crc_reference");
      if (crc7_ref({40'h4000000000, 96'h0}, 40) != 7'h4A)
         report_mismatch("cmd0 crc", 136'(7'h4A), 136'(crc7_ref({40'h4000000000, 96'h0}, 40)));
      if (crc7_ref({40'h5100000000, 96'h0}, 40) != 7'h2A)
         report_mismatch("cmd17 crc", 136'(7'h2A), 136'(crc7_ref({40'h5100000000, 96'h0}, 40)));
      end_test();

      begin_test("reset_and_power_up");
      repeat (RESET_CYCLES) @(posedge sd_clk);
      #DRIVE_DELAY;
      reset_n = 1'b1;
      // frame starts well inside the first 30 high cycles
      wait_cycles(4);
      r = random_bits();
      send_command(build_command(1'b1, r[37:0]));
      wait_cycles(sd_cmd_pkg::INIT_WAIT_CLOCKS);
      in_power_up = 1'b0;
      if (noisy_cycles != 0) report_problem("an output went high during reset or power-up");
      if (rx_data_q.size() != 0) report_problem("a frame during the power-up wait gave cmd_valid");
      rx_data_q.delete();
      rx_ok_q.delete();
      end_test();

      for (int i = 0; i < N_GOOD; i++) begin
         begin_test($sformatf("good_cmd_%0d", i));
         r     = random_bits();
         frame = build_command(1'b1, r[37:0]);
         send_command(frame);
         check_command(frame, 1'b1);
         end_test();
      end

      for (int i = 0; i < N_BADCRC; i++) begin
         begin_test($sformatf("bad_crc_cmd_%0d", i));
         r          = random_bits();
         frame      = build_command(1'b1, r[37:0]);
         flip       = 7'h01 << ($urandom % 7);
         frame[7:1] = frame[7:1] ^ flip;
         send_command(frame);
         check_command(frame, 1'b0);
         end_test();
      end

      for (int i = 0; i < N_TXZERO; i++) begin
         begin_test($sformatf("tx_bit_zero_%0d", i));
         r = random_bits();
         send_command(build_command(1'b0, r[37:0]));
         wait_cycles(60);
         if (rx_data_q.size() != 0) report_problem("a frame with transmission bit 0 was accepted");
         rx_data_q.delete();
         rx_ok_q.delete();
         end_test();
      end

      for (int i = 0; i < N_SHORT; i++) begin
         begin_test($sformatf("short_resp_%0d", i));
         case (i % 4)
            0:       rtype = sd_cmd_pkg::RESP_R1;
            1:       rtype = sd_cmd_pkg::RESP_R6;
            2:       rtype = sd_cmd_pkg::RESP_R7;
            default: rtype = sd_cmd_pkg::RESP_R3;
         endcase
         r            = random_bits();
         r[135:134]   = 2'b00;
         check_response(rtype, r, 1'b0);
         end_test();
      end

      for (int i = 0; i < N_LONG; i++) begin
         begin_test($sformatf("long_resp_%0d", i));
         r          = random_bits();
         r[135:134] = 2'b00;
         check_response(sd_cmd_pkg::RESP_R2, r, (i % 2) == 0);
         end_test();
      end

      $display("tests: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge sd_clk);
      $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+verif
src/sd_cmd_pkg.sv
src/sd_crc7.sv
src/sd_cmd_rx.sv
src/sd_resp_tx.sv
src/sd_cmd_phy.sv
verif/tb_sd_cmd_phy.sv
